/* Makefile */
# Verilator build and run of the decode stage testbench

OBJ_DIR = obj_dir

sim:
	verilator --binary --assert --timing --timescale 1ns/1ps \
		--top-module decode_tb -f project.f --Mdir $(OBJ_DIR) -o decode_sim
	./$(OBJ_DIR)/decode_sim

clean:
	rm -rf $(OBJ_DIR)

.PHONY: sim clean

/* logic/alu_operand_stage.sv */
// operands are only meaningful in the cycle new_request is high; no reset on payload
`timescale 1ns/1ps
`include "decode_cfg.svh"

module alu_operand_stage (
    input  logic                      clk,
    input  logic                      rst,
    decoded_instr_if.unit             bus,
    input  logic                      issue_alu,
    output logic                      new_request,
    output decode_pkg::alu_operand_t  in1,
    output decode_pkg::alu_operand_t  in2,
    output decode_pkg::word_t         shifter_in,
    output logic                      subtract,
    output logic                      arith,
    output logic                      lshift,
    output decode_pkg::alu_op_t       op,
    output decode_pkg::alu_logic_op_t logic_op
);

    decode_pkg::fn3_t          fn3;
    logic                      upper_imm; // lui or auipc
    logic                      sign_ext;
    logic                      sub_next;
    decode_pkg::word_t         rs1_sel;
    decode_pkg::word_t         rs2_sel;
    decode_pkg::word_t         rs1_reversed;
    decode_pkg::alu_op_t       op_next;
    decode_pkg::alu_logic_op_t logic_op_next;

    assign fn3       = bus.instruction[14:12];
    assign upper_imm = bus.instruction[2];
    assign sign_ext  = (fn3 != 3'b011); // sltu compares unsigned

    // ----------------------------------------
    // operand muxing
    // ----------------------------------------
    always_comb begin
        if (upper_imm) begin
            rs1_sel = bus.instruction[5] ? '0 : bus.pc; // lui : auipc
            rs2_sel = {bus.instruction[31:12], 12'b0};
        end else begin
            rs1_sel = bus.rs1_data;
            rs2_sel = bus.instruction[5] ? bus.rs2_data
                                         : decode_pkg::word_t'(signed'(bus.instruction[31:20]));
        end
    end

    assign rs1_reversed = {<<{bus.rs1_data}}; // left shift runs on the right shifter

    // sub for SUB and SLT[U][I]
    assign sub_next = ~upper_imm & ((fn3 == 3'b010) | (fn3 == 3'b011)
                    | ((fn3 == 3'b000) & bus.instruction[5] & bus.instruction[30]));

    always_comb begin
        op_next       = decode_pkg::ALU_ADD_SUB;
        logic_op_next = decode_pkg::ALU_LOGIC_ADD;
        if (!upper_imm) begin
            case (fn3)
                3'b001, 3'b101: op_next       = decode_pkg::ALU_SHIFT;
                3'b010, 3'b011: op_next       = decode_pkg::ALU_SLT;
                3'b100:         logic_op_next = decode_pkg::ALU_LOGIC_XOR;
                3'b110:         logic_op_next = decode_pkg::ALU_LOGIC_OR;
                3'b111:         logic_op_next = decode_pkg::ALU_LOGIC_AND;
                default:        op_next       = decode_pkg::ALU_ADD_SUB;
            endcase
        end
    end

    // ----------------------------------------
    // registered alu inputs
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (issue_alu) begin
            in1        <= {rs1_sel[`DECODE_XLEN-1] & sign_ext, rs1_sel};
            in2        <= {rs2_sel[`DECODE_XLEN-1] & sign_ext, rs2_sel};
            shifter_in <= fn3[2] ? bus.rs1_data : rs1_reversed;
            subtract   <= sub_next;
            arith      <= bus.rs1_data[`DECODE_XLEN-1] & bus.instruction[30]; // sra fill bit
            lshift     <= ~fn3[2];
            op         <= op_next;
            logic_op   <= logic_op_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            new_request <= 1'b0;
        end else begin
            new_request <= issue_alu;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> (new_request == $past(issue_alu)))
        else $error("alu new_request not one cycle after issue");

endmodule

/* logic/branch_operand_stage.sv */
// covers conditional branches, jal and jalr; call/return hints are not generated
`timescale 1ns/1ps

module branch_operand_stage (
    input  logic             clk,
    input  logic             rst,
    decoded_instr_if.unit    bus,
    input  logic             issue_branch,
    output logic             new_request,
    output decode_pkg::word_t rs1,
    output decode_pkg::word_t rs2,
    output decode_pkg::word_t pc,
    output decode_pkg::fn3_t fn3,
    output logic             use_signed,
    output logic             jal,
    output logic             jalr,
    output logic             rdx0
);

    decode_pkg::fn3_t fn3_cur;
    logic             is_jump; // jal or jalr, opcode bit 2

    assign fn3_cur = bus.instruction[14:12];
    assign is_jump = bus.instruction[2];

    always_ff @(posedge clk) begin
        if (issue_branch) begin
            rs1        <= bus.rs1_data;
            rs2        <= bus.rs2_data;
            pc         <= bus.pc;
            fn3        <= fn3_cur;
            use_signed <= ~(fn3_cur[2] & fn3_cur[1]); // bltu, bgeu
            jal        <= bus.instruction[3];
            jalr       <= is_jump & ~bus.instruction[3];
            // no link written for plain branches
            rdx0       <= ~is_jump | (bus.instruction[11:7] == '0);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            new_request <= 1'b0;
        end else begin
            new_request <= issue_branch;
        end
    end

endmodule

/* logic/decode_cfg.svh */
// rv32i base encoding only; widths are fixed by the instruction format and must not change
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

`define DECODE_XLEN   32
`define DECODE_REG_AW 5

// ----------------------------------------
// major opcodes, instruction[6:0]
// ----------------------------------------
`define OPC_LUI       7'b0110111
`define OPC_AUIPC     7'b0010111
`define OPC_JAL       7'b1101111
`define OPC_JALR      7'b1100111
`define OPC_BRANCH    7'b1100011
`define OPC_LOAD      7'b0000011
`define OPC_STORE     7'b0100011
`define OPC_ARITH_IMM 7'b0010011
`define OPC_ARITH     7'b0110011 // bit 25 set is M extension, not supported

`endif

/* logic/decode_pkg.sv */
// types for the decode stage; code values must match the ALU that consumes them
`include "decode_cfg.svh"

package decode_pkg;

    typedef logic [`DECODE_XLEN-1:0]   word_t;
    typedef logic [`DECODE_XLEN:0]     alu_operand_t; // extra sign bit on top
    typedef logic [`DECODE_REG_AW-1:0] reg_addr_t;
    typedef logic [2:0]                fn3_t;
    typedef logic [11:0]               ls_offset_t;
    typedef logic [2:0]                unit_mask_t;   // one-hot, see UNIT_*

    // ----------------------------------------
    // alu result select
    // ----------------------------------------
    typedef logic [1:0] alu_op_t;

    localparam alu_op_t ALU_ADD_SUB = 2'b00;
    localparam alu_op_t ALU_SLT     = 2'b01;
    localparam alu_op_t ALU_SHIFT   = 2'b10;

    // logic path select
    typedef logic [1:0] alu_logic_op_t;

    localparam alu_logic_op_t ALU_LOGIC_ADD = 2'b00;
    localparam alu_logic_op_t ALU_LOGIC_XOR = 2'b01;
    localparam alu_logic_op_t ALU_LOGIC_OR  = 2'b10;
    localparam alu_logic_op_t ALU_LOGIC_AND = 2'b11;

    // ----------------------------------------
    // bit positions in unit_mask_t
    // ----------------------------------------
    localparam int UNIT_ALU    = 0;
    localparam int UNIT_LS     = 1;
    localparam int UNIT_BRANCH = 2;

endpackage

/* logic/decode_top.sv */
// register file and scoreboard live outside; their data and conflict flags come in as ports
`timescale 1ns/1ps

module decode_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      flush,
    input  logic                      valid,
    input  decode_pkg::word_t         instruction,
    input  decode_pkg::word_t         pc,
    input  decode_pkg::word_t         rs1_data,
    input  decode_pkg::word_t         rs2_data,
    input  logic                      rs1_conflict,
    input  logic                      rs2_conflict,
    input  logic                      alu_ready,
    input  logic                      ls_ready,
    input  logic                      branch_ready,
    output logic                      pop,
    output logic                      illegal_instruction,
    output decode_pkg::reg_addr_t     rs1_addr,
    output decode_pkg::reg_addr_t     rs2_addr,
    output logic                      alu_new_request,
    output decode_pkg::alu_operand_t  alu_in1,
    output decode_pkg::alu_operand_t  alu_in2,
    output decode_pkg::word_t         alu_shifter_in,
    output logic                      alu_subtract,
    output logic                      alu_arith,
    output logic                      alu_lshift,
    output decode_pkg::alu_op_t       alu_op,
    output decode_pkg::alu_logic_op_t alu_logic_op,
    output logic                      ls_new_request,
    output decode_pkg::word_t         ls_base,
    output decode_pkg::ls_offset_t    ls_offset,
    output decode_pkg::word_t         ls_store_data,
    output logic                      ls_load,
    output logic                      ls_store,
    output decode_pkg::fn3_t          ls_fn3,
    output logic                      branch_new_request,
    output decode_pkg::word_t         branch_rs1,
    output decode_pkg::word_t         branch_rs2,
    output decode_pkg::word_t         branch_pc,
    output decode_pkg::fn3_t          branch_fn3,
    output logic                      branch_use_signed,
    output logic                      branch_jal,
    output logic                      branch_jalr,
    output logic                      branch_rdx0
);

    decode_pkg::unit_mask_t issue; // one-hot strobe per stage

    decoded_instr_if bus ();

    issue_control issue_control_inst (
        .flush(flush), .valid(valid), .instruction(instruction), .pc(pc),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .rs1_conflict(rs1_conflict), .rs2_conflict(rs2_conflict),
        .alu_ready(alu_ready), .ls_ready(ls_ready), .branch_ready(branch_ready),
        .bus(bus.issue), .issue(issue), .pop(pop),
        .illegal_instruction(illegal_instruction),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr)
    );

    // ----------------------------------------
    // operand stages
    // ----------------------------------------
    alu_operand_stage alu_operand_stage_inst (
        .clk(clk), .rst(rst), .bus(bus.unit), .issue_alu(issue[decode_pkg::UNIT_ALU]),
        .new_request(alu_new_request), .in1(alu_in1), .in2(alu_in2),
        .shifter_in(alu_shifter_in), .subtract(alu_subtract), .arith(alu_arith),
        .lshift(alu_lshift), .op(alu_op), .logic_op(alu_logic_op)
    );

    ls_operand_stage ls_operand_stage_inst (
        .clk(clk), .rst(rst), .bus(bus.unit), .issue_ls(issue[decode_pkg::UNIT_LS]),
        .new_request(ls_new_request), .base(ls_base), .offset(ls_offset),
        .store_data(ls_store_data), .load(ls_load), .store(ls_store), .fn3(ls_fn3)
    );

    branch_operand_stage branch_operand_stage_inst (
        .clk(clk), .rst(rst), .bus(bus.unit),
        .issue_branch(issue[decode_pkg::UNIT_BRANCH]),
        .new_request(branch_new_request), .rs1(branch_rs1), .rs2(branch_rs2),
        .pc(branch_pc), .fn3(branch_fn3), .use_signed(branch_use_signed),
        .jal(branch_jal), .jalr(branch_jalr), .rdx0(branch_rdx0)
    );

endmodule

/* logic/decoded_instr_if.sv */
// instruction under decode plus its register operands; valid only while the buffer presents it
`timescale 1ns/1ps

interface decoded_instr_if;

    decode_pkg::word_t instruction;
    decode_pkg::word_t pc;
    decode_pkg::word_t rs1_data;
    decode_pkg::word_t rs2_data;

    // driven by the issue controller
    modport issue (
        output instruction, pc, rs1_data, rs2_data
    );

    // operand stages only listen
    modport unit (
        input instruction, pc, rs1_data, rs2_data
    );

endinterface

/* logic/issue_control.sv */
// purely combinational; conflict flags must already be settled for the current instruction
`timescale 1ns/1ps
`include "decode_cfg.svh"

module issue_control (
    input  logic                   flush,
    input  logic                   valid,
    input  decode_pkg::word_t      instruction,
    input  decode_pkg::word_t      pc,
    input  decode_pkg::word_t      rs1_data,
    input  decode_pkg::word_t      rs2_data,
    input  logic                   rs1_conflict,
    input  logic                   rs2_conflict,
    input  logic                   alu_ready,
    input  logic                   ls_ready,
    input  logic                   branch_ready,
    decoded_instr_if.issue         bus,
    output decode_pkg::unit_mask_t issue,
    output logic                   pop,
    output logic                   illegal_instruction,
    output decode_pkg::reg_addr_t  rs1_addr,
    output decode_pkg::reg_addr_t  rs2_addr
);

    decode_pkg::reg_addr_t  rd_addr;
    decode_pkg::unit_mask_t target;     // unit the opcode asks for
    decode_pkg::unit_mask_t unit_ready;
    logic                   uses_rs1;
    logic                   uses_rs2;
    logic                   uses_rd;
    logic                   operands_ready;
    logic                   issue_valid;

    assign rs1_addr = instruction[19:15];
    assign rs2_addr = instruction[24:20];
    assign rd_addr  = instruction[11:7];

    // shared bus to the operand stages
    assign bus.instruction = instruction;
    assign bus.pc          = pc;
    assign bus.rs1_data    = rs1_data;
    assign bus.rs2_data    = rs2_data;

    // ----------------------------------------
    // opcode decode
    // ----------------------------------------
    always_comb begin
        uses_rs1            = 1'b0;
        uses_rs2            = 1'b0;
        uses_rd             = 1'b0;
        target              = '0;
        illegal_instruction = 1'b0;
        case (instruction[6:0])
            `OPC_LUI, `OPC_AUIPC: begin
                uses_rd = 1'b1;
                target[decode_pkg::UNIT_ALU] = 1'b1;
            end
            `OPC_ARITH_IMM: begin
                uses_rs1 = 1'b1;
                uses_rd  = 1'b1;
                target[decode_pkg::UNIT_ALU] = 1'b1;
            end
            `OPC_ARITH: begin
                if (instruction[25]) begin
                    illegal_instruction = 1'b1; // mul/div
                end else begin
                    uses_rs1 = 1'b1;
                    uses_rs2 = 1'b1;
                    uses_rd  = 1'b1;
                    target[decode_pkg::UNIT_ALU] = 1'b1;
                end
            end
            `OPC_LOAD: begin
                uses_rs1 = 1'b1;
                uses_rd  = 1'b1;
                target[decode_pkg::UNIT_LS] = 1'b1;
            end
            `OPC_STORE: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                target[decode_pkg::UNIT_LS] = 1'b1;
            end
            `OPC_BRANCH: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                target[decode_pkg::UNIT_BRANCH] = 1'b1;
            end
            `OPC_JAL: begin
                uses_rd = 1'b1;
                target[decode_pkg::UNIT_BRANCH] = 1'b1;
            end
            `OPC_JALR: begin
                uses_rs1 = 1'b1;
                uses_rd  = 1'b1;
                target[decode_pkg::UNIT_BRANCH] = 1'b1;
            end
            default: illegal_instruction = 1'b1; // system, fence, amo and unknown
        endcase
    end

    // ----------------------------------------
    // issue gating
    // ----------------------------------------
    assign unit_ready[decode_pkg::UNIT_ALU] = alu_ready;
    assign unit_ready[decode_pkg::UNIT_LS]  = ls_ready;
    // no writeback to claim, so branch unit can take it anyway
    assign unit_ready[decode_pkg::UNIT_BRANCH] = branch_ready | ~uses_rd | (rd_addr == '0);

    assign issue_valid    = valid & ~flush;
    assign operands_ready = ~((uses_rs1 & rs1_conflict) | (uses_rs2 & rs2_conflict));

    assign issue = target & unit_ready
                 & {$bits(decode_pkg::unit_mask_t){issue_valid & operands_ready}};
    assign pop   = |issue;

    always_comb begin
        assert ($onehot0(issue)) else $error("issue strobe is not one-hot");
        assert (!(pop && illegal_instruction)) else $error("pop on an illegal instruction");
    end

endmodule

/* logic/ls_operand_stage.sv */
// only loads and stores reach this stage; address add is left to the load/store unit
`timescale 1ns/1ps

module ls_operand_stage (
    input  logic                   clk,
    input  logic                   rst,
    decoded_instr_if.unit          bus,
    input  logic                   issue_ls,
    output logic                   new_request,
    output decode_pkg::word_t      base,
    output decode_pkg::ls_offset_t offset,
    output decode_pkg::word_t      store_data,
    output logic                   load,
    output logic                   store,
    output decode_pkg::fn3_t       fn3
);

    logic                   is_store;
    decode_pkg::ls_offset_t offset_next;

    assign is_store = bus.instruction[5]; // store 0100011 vs load 0000011

    // s-type splits the immediate around rd
    assign offset_next = is_store ? {bus.instruction[31:25], bus.instruction[11:7]}
                                  : bus.instruction[31:20];

    always_ff @(posedge clk) begin
        if (issue_ls) begin
            base       <= bus.rs1_data;
            offset     <= offset_next;
            store_data <= bus.rs2_data;
            load       <= ~is_store;
            store      <= is_store;
            fn3        <= bus.instruction[14:12]; // width and sign
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            new_request <= 1'b0;
        end else begin
            new_request <= issue_ls;
        end
    end

endmodule

/* project.f */
+incdir+logic
+incdir+verification
logic/decode_pkg.sv
logic/decoded_instr_if.sv
logic/issue_control.sv
logic/alu_operand_stage.sv
logic/ls_operand_stage.sv
logic/branch_operand_stage.sv
logic/decode_top.sv
verification/decode_tb.sv

/* verification/decode_vectors.svh */
// one entry per cycle, back to back; conflict is {rs2, rs1}, ready and unit follow unit_mask_t
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

// columns: instruction, pc, conflict, ready, flush, expected pop, illegal, unit
localparam int NUM_VECTORS = 27;

vector_t vectors [NUM_VECTORS] = '{
    // ----------------------------------------
    // unit selection and formatting
    // ----------------------------------------
    '{32'h123450B7, 32'h00001000, 2'b00, 3'b111, 1'b0, 1'b1, 1'b0, 3'b001}, // lui x1
    '{32'hABCDE117, 32'h00002004, 2'b00, 3'b111, 1'b0, 1'b1, 1'b0, 3'b001}, // auipc x2
    '{32'hFFB20193, 32'h00002008, 2'b00, 3'b111, 1'b0, 1'b1, 1'b0, 3'b001}, // addi -5
    '{32'h007302B3, 32'h0000200C, 2'b00, 3'b111, 1'b0, 1'b1, 1'b0, 3'b001}, // add
    '{32'h407302B3, 32'h00002010, 2'b00, 3'b111, 1'b0, 1'b1, 1'b0, 3'b001}, // sub
    '{32'h003120B3, 32'h00002014, 2'b00, 3'b111, 1'b0, 1'b1, 1'b0, 3'b001}, // slt
    '{32'h00A4B433, 32'h00002018, 2'b00, 3'b111, 1'b0, 1'b1, 1'b0, 3'b001}, // sltu
    '{32'h00D645B3, 32'h0000201C, 2'b00, 3'b111, 1'b0, 1'b1, 1'b0, 3'b001}, // xor
    '{32'h01079733, 32'h00002020, 2'b00, 3'b111, 1'b0, 1'b1, 1'b0, 3'b001}, // sll
    '{32'hFF892883, 32'h00002024, 2'b00, 3'b111, 1'b0, 1'b1, 1'b0, 3'b010}, // lw -8
    '{32'h133A21A3, 32'h00002028, 2'b00, 3'b111, 1'b0, 1'b1, 1'b0, 3'b010}, // sw 0x123
    '{32'h00208063, 32'h0000202C, 2'b00, 3'b111, 1'b0, 1'b1, 1'b0, 3'b100}, // beq
    '{32'h0041E063, 32'h00002030, 2'b00, 3'b111, 1'b0, 1'b1, 1'b0, 3'b100}, // bltu
    '{32'h000000EF, 32'h00002034, 2'b00, 3'b111, 1'b0, 1'b1, 1'b0, 3'b100}, // jal x1
    '{32'h000280E7, 32'h00002038, 2'b00, 3'b111, 1'b0, 1'b1, 1'b0, 3'b100}, // jalr x1
    // ----------------------------------------
    // hazards and back-pressure
    // ----------------------------------------
    '{32'h007302B3, 32'h00003000, 2'b01, 3'b111, 1'b0, 1'b0, 1'b0, 3'b000}, // add, rs1 busy
    '{32'hFFB20193, 32'h00003004, 2'b10, 3'b111, 1'b0, 1'b1, 1'b0, 3'b001}, // addi ignores rs2
    '{32'h133A21A3, 32'h00003008, 2'b10, 3'b111, 1'b0, 1'b0, 1'b0, 3'b000}, // sw, rs2 busy
    '{32'hFF892883, 32'h0000300C, 2'b00, 3'b101, 1'b0, 1'b0, 1'b0, 3'b000}, // lw, ls busy
    '{32'h007302B3, 32'h00003010, 2'b00, 3'b110, 1'b0, 1'b0, 1'b0, 3'b000}, // add, alu busy
    '{32'h007302B3, 32'h00003014, 2'b00, 3'b111, 1'b1, 1'b0, 1'b0, 3'b000}, // add, flush
    '{32'h000000EF, 32'h00003018, 2'b00, 3'b011, 1'b0, 1'b0, 1'b0, 3'b000}, // jal x1 waits
    '{32'h0000006F, 32'h0000301C, 2'b00, 3'b011, 1'b0, 1'b1, 1'b0, 3'b100}, // jal x0 goes
    '{32'h00208063, 32'h00003020, 2'b00, 3'b011, 1'b0, 1'b1, 1'b0, 3'b100}, // beq, no link
    // ----------------------------------------
    // illegal opcodes
    // ----------------------------------------
    '{32'h300110F3, 32'h00004000, 2'b00, 3'b111, 1'b0, 1'b0, 1'b1, 3'b000}, // csrrw
    '{32'h0FF0000F, 32'h00004004, 2'b00, 3'b111, 1'b0, 1'b0, 1'b1, 3'b000}, // fence
    '{32'h023100B3, 32'h00004008, 2'b00, 3'b111, 1'b0, 1'b0, 1'b1, 3'b000}  // mul
};

`endif

/* verification/decode_tb.sv */
// one table entry per cycle; results of an issue are checked at the following falling edge
`timescale 1ns/1ps
`include "decode_cfg.svh"

module decode_tb;

    localparam int CLK_PERIOD = 100;

    typedef struct packed {
        decode_pkg::word_t      instruction;
        decode_pkg::word_t      pc;
        logic [1:0]             conflict; // {rs2, rs1}
        decode_pkg::unit_mask_t ready;
        logic                   flush;
        logic                   pop;
        logic                   illegal;
        decode_pkg::unit_mask_t unit;
    } vector_t;

    `include "decode_vectors.svh"

    logic clk, rst, flush, valid;
    logic rs1_conflict, rs2_conflict, alu_ready, ls_ready, branch_ready;
    decode_pkg::word_t instruction, pc, rs1_data, rs2_data;
    logic pop, illegal_instruction;
    decode_pkg::reg_addr_t rs1_addr, rs2_addr;
    logic alu_new_request, alu_subtract, alu_arith, alu_lshift;
    decode_pkg::alu_operand_t alu_in1, alu_in2;
    decode_pkg::word_t alu_shifter_in;
    decode_pkg::alu_op_t alu_op;
    decode_pkg::alu_logic_op_t alu_logic_op;
    logic ls_new_request, ls_load, ls_store;
    decode_pkg::word_t ls_base, ls_store_data;
    decode_pkg::ls_offset_t ls_offset;
    decode_pkg::fn3_t ls_fn3, branch_fn3;
    logic branch_new_request, branch_use_signed, branch_jal, branch_jalr, branch_rdx0;
    decode_pkg::word_t branch_rs1, branch_rs2, branch_pc;
    decode_pkg::word_t rng_state;

    decode_top decode_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((NUM_VECTORS + 10) * CLK_PERIOD); // reset, table and margin
        $display("watchdog expired before the table was finished, the run timed out");
        $display("TESTS FAILED");
        $fatal(1, "timeout");
    end

    // ----------------------------------------
    // helpers and compare tasks
    // ----------------------------------------
    function automatic decode_pkg::word_t xorshift(input decode_pkg::word_t x);
        decode_pkg::word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic decode_pkg::word_t reverse_bits(input decode_pkg::word_t x);
        decode_pkg::word_t y;
        for (int b = 0; b < `DECODE_XLEN; b++) begin
            y[b] = x[`DECODE_XLEN-1-b];
        end
        return y;
    endfunction

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_word(input string name, input decode_pkg::word_t got,
                              input decode_pkg::word_t exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_alu_operand(input string name, input decode_pkg::alu_operand_t got,
                                     input decode_pkg::alu_operand_t exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_alu_op(input string name, input decode_pkg::alu_op_t got,
                                input decode_pkg::alu_op_t exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // ----------------------------------------
    // expected operands per unit
    // ----------------------------------------
    task automatic compare_alu_outputs(input vector_t v, input decode_pkg::word_t r1,
                                       input decode_pkg::word_t r2);
        logic [6:0]                opcode;
        decode_pkg::fn3_t          f3;
        decode_pkg::word_t         a;
        decode_pkg::word_t         b;
        logic                      upper;
        logic                      sign_on;
        logic                      sub_exp;
        logic                      arith_exp;
        decode_pkg::alu_op_t       op_exp;
        decode_pkg::alu_logic_op_t logic_exp;
        opcode  = v.instruction[6:0];
        f3      = v.instruction[14:12];
        upper   = (opcode == `OPC_LUI) || (opcode == `OPC_AUIPC);
        a       = r1;
        b       = r2;
        if (upper) begin
            a = (opcode == `OPC_LUI) ? '0 : v.pc;
            b = {v.instruction[31:12], 12'h000};
        end else if (opcode == `OPC_ARITH_IMM) begin
            b = {{(`DECODE_XLEN-12){v.instruction[31]}}, v.instruction[31:20]};
        end
        sign_on = (f3 != 3'b011); // unsigned compare drops the extra bit
        sub_exp = !upper && ((f3 == 3'b010) || (f3 == 3'b011)
                  || ((opcode == `OPC_ARITH) && (f3 == 3'b000) && v.instruction[30]));
        arith_exp = v.instruction[30] ? r1[`DECODE_XLEN-1] : 1'b0; // sra fills with rs1 sign
        op_exp    = decode_pkg::ALU_ADD_SUB;
        logic_exp = decode_pkg::ALU_LOGIC_ADD;
        if (!upper) begin
            if (f3 == 3'b001 || f3 == 3'b101) op_exp = decode_pkg::ALU_SHIFT;
            if (f3 == 3'b010 || f3 == 3'b011) op_exp = decode_pkg::ALU_SLT;
            if (f3 == 3'b100) logic_exp = decode_pkg::ALU_LOGIC_XOR;
            if (f3 == 3'b110) logic_exp = decode_pkg::ALU_LOGIC_OR;
            if (f3 == 3'b111) logic_exp = decode_pkg::ALU_LOGIC_AND;
        end
        check_alu_operand("alu_in1", alu_in1, {a[`DECODE_XLEN-1] & sign_on, a});
        check_alu_operand("alu_in2", alu_in2, {b[`DECODE_XLEN-1] & sign_on, b});
        check_flag("alu_subtract", alu_subtract, sub_exp);
        check_flag("alu_arith", alu_arith, arith_exp);
        check_alu_op("alu_op", alu_op, op_exp);
        check_alu_op("alu_logic_op", alu_logic_op, logic_exp);
        if (!upper && f3 == 3'b001) begin
            check_word("alu_shifter_in", alu_shifter_in, reverse_bits(r1));
            check_flag("alu_lshift", alu_lshift, 1'b1);
        end
    endtask

    task automatic compare_ls_outputs(input vector_t v, input decode_pkg::word_t r1,
                                      input decode_pkg::word_t r2);
        logic                   is_store;
        decode_pkg::ls_offset_t off;
        is_store = (v.instruction[6:0] == `OPC_STORE);
        off      = is_store ? {v.instruction[31:25], v.instruction[11:7]}
                            : v.instruction[31:20];
        check_word("ls_base", ls_base, r1);
        check_word("ls_offset", {20'h0, ls_offset}, {20'h0, off});
        check_word("ls_fn3", {29'h0, ls_fn3}, {29'h0, v.instruction[14:12]});
        check_flag("ls_load", ls_load, !is_store);
        check_flag("ls_store", ls_store, is_store);
        if (is_store) begin
            check_word("ls_store_data", ls_store_data, r2);
        end
    endtask

    task automatic compare_branch_outputs(input vector_t v, input decode_pkg::word_t r1,
                                          input decode_pkg::word_t r2);
        logic [6:0]       opcode;
        decode_pkg::fn3_t f3;
        opcode = v.instruction[6:0];
        f3     = v.instruction[14:12];
        check_word("branch_rs1", branch_rs1, r1);
        check_word("branch_rs2", branch_rs2, r2);
        check_word("branch_pc", branch_pc, v.pc);
        check_word("branch_fn3", {29'h0, branch_fn3}, {29'h0, f3});
        check_flag("branch_jal", branch_jal, opcode == `OPC_JAL);
        check_flag("branch_jalr", branch_jalr, opcode == `OPC_JALR);
        // conditional branches write no link
        check_flag("branch_rdx0", branch_rdx0,
                   (opcode == `OPC_BRANCH) || (v.instruction[11:7] == 5'd0));
        if (opcode == `OPC_BRANCH) begin
            check_flag("branch_use_signed", branch_use_signed, !(f3 == 3'b110 || f3 == 3'b111));
        end
    endtask

    // ----------------------------------------
    // stimulus loop
    // ----------------------------------------
    initial begin
        vector_t                vec;
        vector_t                prev;
        decode_pkg::word_t      prev_rs1;
        decode_pkg::word_t      prev_rs2;
        decode_pkg::unit_mask_t fired; // unit expected to see new_request now
        rst          = 1'b1;
        flush        = 1'b0;
        valid        = 1'b0;
        instruction  = '0;
        pc           = '0;
        rs1_data     = '0;
        rs2_data     = '0;
        rs1_conflict = 1'b0;
        rs2_conflict = 1'b0;
        alu_ready    = 1'b0;
        ls_ready     = 1'b0;
        branch_ready = 1'b0;
        rng_state    = 32'd51;
        prev         = '0;
        prev_rs1     = '0;
        prev_rs2     = '0;
        fired        = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i <= NUM_VECTORS; i++) begin
            check_flag("alu_new_request", alu_new_request, fired[decode_pkg::UNIT_ALU]);
            check_flag("ls_new_request", ls_new_request, fired[decode_pkg::UNIT_LS]);
            check_flag("branch_new_request", branch_new_request,
                       fired[decode_pkg::UNIT_BRANCH]);
            if (fired[decode_pkg::UNIT_ALU]) compare_alu_outputs(prev, prev_rs1, prev_rs2);
            if (fired[decode_pkg::UNIT_LS]) compare_ls_outputs(prev, prev_rs1, prev_rs2);
            if (fired[decode_pkg::UNIT_BRANCH]) compare_branch_outputs(prev, prev_rs1, prev_rs2);

            if (i < NUM_VECTORS) begin
                vec          = vectors[i];
                rng_state    = xorshift(rng_state);
                rs1_data     = rng_state;
                rng_state    = xorshift(rng_state);
                rs2_data     = rng_state;
                instruction  = vec.instruction;
                pc           = vec.pc;
                rs1_conflict = vec.conflict[0];
                rs2_conflict = vec.conflict[1];
                alu_ready    = vec.ready[decode_pkg::UNIT_ALU];
                ls_ready     = vec.ready[decode_pkg::UNIT_LS];
                branch_ready = vec.ready[decode_pkg::UNIT_BRANCH];
                flush        = vec.flush;
                valid        = 1'b1;
                #(CLK_PERIOD / 4); // combinational outputs, mid low phase
                check_flag("pop", pop, vec.pop);
                check_flag("illegal_instruction", illegal_instruction, vec.illegal);
                check_word("rs1_addr", {27'h0, rs1_addr}, {27'h0, vec.instruction[19:15]});
                check_word("rs2_addr", {27'h0, rs2_addr}, {27'h0, vec.instruction[24:20]});
                prev     = vec;
                prev_rs1 = rs1_data;
                prev_rs2 = rs2_data;
                fired    = vec.pop ? vec.unit : '0;
            end else begin
                valid = 1'b0;
            end
            @(negedge clk);
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule
